// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ghrd
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
ghrd_pkg.sv
key_debounce.sv
reset_req_pulser.sv
fabric_status.sv
ghrd_fabric_top.sv
tb_clock_gen.sv
ghrd_checker.sv
ghrd_props.sv
tb_ghrd.sv

// File: fabric_status.sv
/* heartbeat, led bus and trace events */
`timescale 1ns/1ns
`default_nettype none

module fabric_status #(
  parameter int unsigned heartbeat_half = ghrd_pkg::heartbeat_half_default
) (
  input  wire                    fpga_clk_50,
  input  wire                    hps_fpga_reset_n,
  input  wire ghrd_pkg::key_vec_t   key_stable,   // from the debouncer
  input  wire ghrd_pkg::reset_req_t req_pulse,    // from the pulser
  input  wire ghrd_pkg::sw_vec_t    sw,
  input  wire ghrd_pkg::led_pio_t   led_pio,
  output ghrd_pkg::led_vec_t     led,
  output ghrd_pkg::key_vec_t     buttons,         // to the button pio
  output ghrd_pkg::stm_events_t  stm_events,
  output ghrd_pkg::reset_req_t   reset_req_n      // active low to the hps
);

  import ghrd_pkg::*;

  localparam int hb_w = (heartbeat_half > 1) ? $clog2(heartbeat_half) : 1;
  localparam logic [hb_w-1:0] hb_last = hb_w'(heartbeat_half - 1);

  // ======================================================================
  // heartbeat
  // ======================================================================

  logic [hb_w-1:0] hb_cnt;
  logic            hb_level;   // blinks on led[0]

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hb_cnt   <= '0;
      hb_level <= 1'b0;
    end
    else if (hb_cnt == hb_last)
    begin
      hb_cnt   <= '0;
      hb_level <= ~hb_level;   // half period reached
    end
    else
    begin
      hb_cnt <= hb_cnt + 1'b1;
    end
  end

  // ======================================================================
  // registered outputs toward the board and the hps
  // ======================================================================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      led         <= '0;
      buttons     <= '1;   // keys released
      stm_events  <= '0;
      reset_req_n <= '1;   // no request pending
    end
    else
    begin
      led         <= {led_pio, hb_level};
      buttons     <= key_stable;
      // pad, switches, hps led value, keys, top to bottom
      stm_events  <= {{stm_pad_width{1'b0}}, sw, led_pio, key_stable};
      reset_req_n <= reset_req_t'(~req_pulse);
    end
  end

endmodule

`default_nettype wire

// File: ghrd_checker.sv
/* ghrd fabric output checker */
`timescale 1ns/1ns
`default_nettype none

module ghrd_checker #(
  parameter int debounce_cycles = 8,
  parameter int heartbeat_half  = 20
) (
  input  wire                        fpga_clk_50,
  input  wire                        hps_fpga_reset_n,
  input  wire ghrd_pkg::key_vec_t    key,
  input  wire ghrd_pkg::sw_vec_t     sw,
  input  wire ghrd_pkg::led_pio_t    led_pio,
  input  wire ghrd_pkg::reset_req_t  reset_req,
  input  wire ghrd_pkg::led_vec_t    led,
  input  wire ghrd_pkg::key_vec_t    buttons,
  input  wire ghrd_pkg::stm_events_t stm_events,
  input  wire ghrd_pkg::reset_req_t  reset_req_n,
  output int                         err_cnt
);

  import ghrd_pkg::*;

  // cold, warm, debug in struct bit order
  localparam int chan_len [3] = '{cold_pulse_len, warm_pulse_len, debug_pulse_len};

  int         errors = 0;
  key_vec_t   key_q;          // last sampled inputs and outputs
  key_vec_t   btn_q;
  sw_vec_t    sw_q;
  led_pio_t   pio_q;
  reset_req_t req_q;
  logic       seen;           // one sample taken out of reset
  int         key_age [2];    // cycles since each key last changed
  logic       led0_q;
  int         hb_age;         // cycles since last heartbeat toggle
  logic       hb_seen;
  logic [3:0] req_dl [3];     // request edges, delayed to the output
  int         req_left [3];   // predicted low cycles still due

  assign err_cnt = errors;

  task automatic report(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // ======================================================================
  // prediction from values sampled before the clock edge
  // ======================================================================

  always @(posedge fpga_clk_50)
  begin
    if (!hps_fpga_reset_n)
    begin
      if (buttons != '1 || reset_req_n != '1 || led[0] != 1'b0)
        report("outputs not at reset values");
      key_q   = '1;
      btn_q   = '1;
      req_q   = '0;
      seen    = 1'b0;
      led0_q  = 1'b0;
      hb_age  = 0;
      hb_seen = 1'b0;
      for (int i = 0; i < 2; i++)
        key_age[i] = 100;   // long settled
      for (int c = 0; c < 3; c++)
      begin
        req_dl[c]   = '0;
        req_left[c] = 0;
      end
    end
    else
    begin
      // key change reaches buttons in debounce+3 .. debounce+4
      for (int i = 0; i < 2; i++)
      begin
        key_age[i] = (key[i] != key_q[i]) ? 1 : key_age[i] + 1;
        if (buttons[i] != btn_q[i] && (buttons[i] != key[i] ||
            key_age[i] < debounce_cycles + 3 || key_age[i] > debounce_cycles + 4))
          report("buttons changed without a settled key");
        else if (buttons[i] != key[i] && key_age[i] > debounce_cycles + 4)
          report("key change did not reach buttons in time");
      end
      // trace vector and led bus trail their inputs by one cycle
      if (seen && stm_events != {{stm_pad_width{1'b0}}, sw_q, pio_q, buttons})
        report("stm_events mismatch");
      if (seen && led[7:1] != pio_q)
        report("led[7:1] does not follow led_pio");
      // heartbeat period
      hb_age = hb_age + 1;
      if (led[0] != led0_q)
      begin
        if (hb_seen && hb_age != heartbeat_half)
          report("heartbeat toggle interval wrong");
        hb_seen = 1'b1;
        hb_age  = 0;
      end
      else if (hb_age > heartbeat_half + 4)
        report("heartbeat stopped toggling");
      // request edge shows on reset_req_n 4 cycles later
      for (int c = 0; c < 3; c++)
      begin
        if (reset_req_n[c] != (req_left[c] == 0))
          report("reset_req_n pulse timing wrong");
        req_dl[c] = {req_dl[c][2:0], reset_req[c] & ~req_q[c]};
        if (req_left[c] > 0)
          req_left[c]--;    // edges during a running pulse are dropped
        else if (req_dl[c][3])
          req_left[c] = chan_len[c];
      end
      key_q  = key;
      btn_q  = buttons;
      sw_q   = sw;
      pio_q  = led_pio;
      req_q  = reset_req;
      led0_q = led[0];
      seen   = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: ghrd_fabric_top.sv
/* ghrd fabric top */
`timescale 1ns/1ns
`default_nettype none

module ghrd_fabric_top #(
  parameter int unsigned debounce_cycles = ghrd_pkg::debounce_cycles_default,
  parameter int unsigned heartbeat_half  = ghrd_pkg::heartbeat_half_default
) (
  input  wire                       fpga_clk_50,
  input  wire                       hps_fpga_reset_n,
  input  wire ghrd_pkg::key_vec_t   key,           // board keys, active low
  input  wire ghrd_pkg::sw_vec_t    sw,            // dip switches
  input  wire ghrd_pkg::led_pio_t   led_pio,       // hps led pio value
  input  wire ghrd_pkg::reset_req_t reset_req,     // request levels
  output wire ghrd_pkg::led_vec_t   led,
  output wire ghrd_pkg::key_vec_t   buttons,
  output wire ghrd_pkg::stm_events_t stm_events,
  output wire ghrd_pkg::reset_req_t reset_req_n
);

  import ghrd_pkg::*;

  wire key_vec_t   key_stable;   // debounced keys
  wire reset_req_t req_pulse;    // stretched requests, active high

  // ======================================================================
  // key and reset request front ends
  // ======================================================================

  key_debounce #(
    .debounce_cycles (debounce_cycles)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .key_stable       (key_stable)
  );

  reset_req_pulser u_reset_req_pulser (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .reset_req        (reset_req),
    .req_pulse        (req_pulse)
  );

  // ======================================================================
  // outputs, all registered in here
  // ======================================================================

  fabric_status #(
    .heartbeat_half (heartbeat_half)
  ) u_fabric_status (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key_stable       (key_stable),
    .req_pulse        (req_pulse),
    .sw               (sw),
    .led_pio          (led_pio),
    .led              (led),
    .buttons          (buttons),
    .stm_events       (stm_events),
    .reset_req_n      (reset_req_n)
  );

endmodule

`default_nettype wire

// File: ghrd_pkg.sv
/* ghrd fabric shared definitions */
`default_nettype none

package ghrd_pkg;

  // ======================================================================
  // bus widths
  // ======================================================================

  typedef logic [1:0]  key_vec_t;     // KEY[1:0], active low
  typedef logic [3:0]  sw_vec_t;      // dip switch bank
  typedef logic [6:0]  led_pio_t;     // led value from the hps side
  typedef logic [7:0]  led_vec_t;     // board led bus
  typedef logic [27:0] stm_events_t;  // stm hw event vector

  // one bit per hps reset request
  // packed msb first, so cold sits in bit 0, warm in 1, debug in 2
  typedef struct packed {
    logic debug;
    logic warm;
    logic cold;
  } reset_req_t;

  // ======================================================================
  // reset request stretch lengths, in fpga_clk_50 cycles
  // ======================================================================

  localparam int cold_pulse_len  = 6;
  localparam int warm_pulse_len  = 2;
  localparam int debug_pulse_len = 32;   // longest channel

  // stretch counter, holds len-1 of the longest channel
  typedef logic [$clog2(debug_pulse_len)-1:0] pulse_cnt_t;

  // ======================================================================
  // default timeouts
  // ======================================================================

  localparam int unsigned debounce_cycles_default = 50000;     // 1 ms @ 50 MHz
  localparam int unsigned heartbeat_half_default  = 25000000;  // 0.5 s @ 50 MHz

  // zero bits above sw in the event vector
  localparam int stm_pad_width = 15;

endpackage

`default_nettype wire

// File: ghrd_props.sv
/* ghrd fabric assertions */
`timescale 1ns/1ns
`default_nettype none

module ghrd_props (
  input wire                        fpga_clk_50,
  input wire                        hps_fpga_reset_n,
  input wire ghrd_pkg::led_vec_t    led,
  input wire ghrd_pkg::key_vec_t    buttons,
  input wire ghrd_pkg::stm_events_t stm_events,
  input wire ghrd_pkg::reset_req_t  reset_req_n
);

  import ghrd_pkg::*;

  a_reset_values: assert property (@(posedge fpga_clk_50)
    !hps_fpga_reset_n |-> (buttons == '1 && reset_req_n == '1 && !led[0]))
    else $error("outputs not at reset values");

  a_pad_zero: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    stm_events[$bits(stm_events_t)-1 -: stm_pad_width] == '0)
    else $error("stm_events pad bits not zero");

  // on release, low for exactly len samples with high just before
  a_cold_len: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $rose(reset_req_n.cold) |-> (!$past(reset_req_n.cold, cold_pulse_len) &&
                                 $past(reset_req_n.cold, cold_pulse_len + 1)))
    else $error("cold request length wrong");

  a_warm_len: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $rose(reset_req_n.warm) |-> (!$past(reset_req_n.warm, warm_pulse_len) &&
                                 $past(reset_req_n.warm, warm_pulse_len + 1)))
    else $error("warm request length wrong");

  a_debug_len: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $rose(reset_req_n.debug) |-> (!$past(reset_req_n.debug, debug_pulse_len) &&
                                  $past(reset_req_n.debug, debug_pulse_len + 1)))
    else $error("debug request length wrong");

endmodule

bind ghrd_fabric_top ghrd_props u_props (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .led              (led),
  .buttons          (buttons),
  .stm_events       (stm_events),
  .reset_req_n      (reset_req_n)
);

`default_nettype wire

// File: key_debounce.sv
/* key debouncer, active-low keys */
`timescale 1ns/1ns
`default_nettype none

module key_debounce #(
  parameter int unsigned debounce_cycles = ghrd_pkg::debounce_cycles_default
) (
  input  wire                fpga_clk_50,
  input  wire                hps_fpga_reset_n,
  input  wire ghrd_pkg::key_vec_t key,         // raw pins, low = pressed
  output ghrd_pkg::key_vec_t key_stable        // debounced, low = pressed
);

  import ghrd_pkg::*;

  localparam int n_keys = $bits(key_vec_t);

  // counter only has to reach debounce_cycles-1
  localparam int cnt_w = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

  // ======================================================================
  // two-flop synchronizer
  // ======================================================================

  key_vec_t key_meta;   // first stage, may go metastable
  key_vec_t key_sync;   // safe to use from here

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;   // released
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ======================================================================
  // per-key stable-time counter
  // ======================================================================

  for (genvar i = 0; i < n_keys; i++)
  begin : g_key
    logic [cnt_w-1:0] cnt;       // cycles the key has differed
    logic             stable_q;  // current accepted level

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        cnt      <= '0;
        stable_q <= 1'b1;
      end
      else if (key_sync[i] == stable_q)
      begin
        cnt <= '0;                  // agrees again, glitch dropped
      end
      else if (cnt == cnt_last)
      begin
        stable_q <= key_sync[i];    // held long enough, accept it
        cnt      <= '0;
      end
      else
      begin
        cnt <= cnt + 1'b1;
      end
    end

    assign key_stable[i] = stable_q;
  end

endmodule

`default_nettype wire

// File: reset_req_pulser.sv
/* hps reset request stretcher */
`timescale 1ns/1ns
`default_nettype none

module reset_req_pulser (
  input  wire                   fpga_clk_50,
  input  wire                   hps_fpga_reset_n,
  input  wire ghrd_pkg::reset_req_t reset_req,   // request levels
  output ghrd_pkg::reset_req_t  req_pulse        // stretched, active high
);

  import ghrd_pkg::*;

  localparam int n_chan = $bits(reset_req_t);

  // ======================================================================
  // synchronizer and rising-edge detect
  // ======================================================================

  logic [n_chan-1:0] req_meta;   // first sync stage
  logic [n_chan-1:0] req_sync;   // second sync stage
  logic [n_chan-1:0] req_prev;   // last cycle's level, for the edge
  logic [n_chan-1:0] req_rise;   // one-cycle edge strobe
  logic [n_chan-1:0] pulse_q;    // per-channel busy flags

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_meta <= '0;
      req_sync <= '0;
      req_prev <= '0;
    end
    else
    begin
      req_meta <= reset_req;
      req_sync <= req_meta;
      req_prev <= req_sync;
    end
  end

  assign req_rise = req_sync & ~req_prev;   // rising only

  // ======================================================================
  // per-channel stretch counters
  // ======================================================================

  for (genvar i = 0; i < n_chan; i++)
  begin : g_chan
    // bit order follows reset_req_t: cold, warm, debug
    localparam int len = (i == 0) ? cold_pulse_len :
                         (i == 1) ? warm_pulse_len : debug_pulse_len;
    localparam pulse_cnt_t cnt_init = pulse_cnt_t'(len - 1);

    pulse_cnt_t cnt;    // cycles left after this one
    logic       busy;   // stretched request active

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
      if (!hps_fpga_reset_n)
      begin
        cnt  <= '0;
        busy <= 1'b0;
      end
      else if (!busy)
      begin
        if (req_rise[i])
        begin
          busy <= 1'b1;       // start, high for len cycles
          cnt  <= cnt_init;
        end
      end
      else if (cnt == '0)
      begin
        busy <= 1'b0;         // edges seen while busy are dropped
      end
      else
      begin
        cnt <= cnt - 1'b1;
      end
    end

    assign pulse_q[i] = busy;
  end

  assign req_pulse = reset_req_t'(pulse_q);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic fpga_clk_50,
  output logic hps_fpga_reset_n
);

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #2 fpga_clk_50 = ~fpga_clk_50;   // 4 ns period
  end

  initial
  begin
    hps_fpga_reset_n = 1'b1;
    #1 hps_fpga_reset_n = 1'b0;              // real falling edge for the async flops
    repeat (3) @(posedge fpga_clk_50);       // held for 3 rising edges
    hps_fpga_reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_ghrd.sv
/* ghrd fabric testbench */
`timescale 1ns/1ns
`default_nettype none

module tb_ghrd;

  import ghrd_pkg::*;

  localparam int unsigned tb_debounce  = 8;
  localparam int unsigned tb_heartbeat = 20;
  localparam int reset_timeout  = 20;    // cycles
  localparam int settle_timeout = 100;
  localparam int n_rows = 13;

  // one stimulus step
  typedef struct packed {
    key_vec_t   key;
    logic [7:0] hold;      // cycles to hold this row
    reset_req_t req;
    sw_vec_t    sw;
    led_pio_t   led_pio;
  } stim_row_t;

  logic        fpga_clk_50;
  logic        hps_fpga_reset_n;
  key_vec_t    key;
  sw_vec_t     sw;
  led_pio_t    led_pio;
  reset_req_t  reset_req;
  led_vec_t    led;
  key_vec_t    buttons;
  stm_events_t stm_events;
  reset_req_t  reset_req_n;
  int          check_errors;
  int          timeouts;
  int          seed;
  int          wait_cnt;
  int          row_idx;
  stim_row_t   rows [n_rows];

  tb_clock_gen u_clk (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n)
  );

  ghrd_fabric_top #(
    .debounce_cycles (tb_debounce),
    .heartbeat_half  (tb_heartbeat)
  ) u_dut (
    .fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
    .key (key), .sw (sw), .led_pio (led_pio), .reset_req (reset_req),
    .led (led), .buttons (buttons), .stm_events (stm_events), .reset_req_n (reset_req_n)
  );

  ghrd_checker #(
    .debounce_cycles (tb_debounce),
    .heartbeat_half  (tb_heartbeat)
  ) u_chk (
    .fpga_clk_50 (fpga_clk_50), .hps_fpga_reset_n (hps_fpga_reset_n),
    .key (key), .sw (sw), .led_pio (led_pio), .reset_req (reset_req),
    .led (led), .buttons (buttons), .stm_events (stm_events),
    .reset_req_n (reset_req_n), .err_cnt (check_errors)
  );

  // sw and led_pio drawn from the seeded generator
  function automatic stim_row_t make_row(key_vec_t k, int hold, reset_req_t r);
    stim_row_t   row;
    logic [31:0] rnd;
    rnd         = $random(seed);
    row.key     = k;
    row.hold    = 8'(hold);
    row.req     = r;
    row.sw      = rnd[3:0];
    row.led_pio = rnd[14:8];
    return row;
  endfunction

  // ======================================================================
  // stimulus table and main sequence
  // ======================================================================

  initial
  begin
    seed      = 32'h68f4_8ffc;
    key       = '1;             // released
    sw        = '0;
    led_pio   = '0;
    reset_req = '0;
    timeouts  = 0;
    rows[0]  = make_row(2'b11, 16, 3'b000);   // idle
    rows[1]  = make_row(2'b10, 20, 3'b001);   // key0 press, cold edge
    rows[2]  = make_row(2'b11, 3, 3'b000);    // key0 glitch of 3 cycles
    rows[3]  = make_row(2'b10, 20, 3'b010);   // warm edge
    rows[4]  = make_row(2'b11, 20, 3'b000);   // key0 release
    rows[5]  = make_row(2'b01, 5, 3'b100);    // key1 glitch, debug edge
    rows[6]  = make_row(2'b11, 6, 3'b000);
    rows[7]  = make_row(2'b11, 10, 3'b100);   // debug edge inside its pulse
    rows[8]  = make_row(2'b00, 40, 3'b000);   // both keys
    rows[9]  = make_row(2'b11, 30, 3'b111);   // all requests at once
    rows[10] = make_row(2'b11, 4, 3'b000);
    rows[11] = make_row(2'b11, 10, 3'b011);   // cold and warm again
    rows[12] = make_row(2'b11, 40, 3'b000);   // drain
    wait_cnt = 0;   // reset goes active just after time 0
    while (hps_fpga_reset_n !== 1'b0 && wait_cnt < reset_timeout)
    begin
      @(posedge fpga_clk_50);
      wait_cnt++;
    end
    if (hps_fpga_reset_n !== 1'b0)
    begin
      $display("timeout: reset was never asserted");
      timeouts++;
    end
    wait_cnt = 0;
    while (hps_fpga_reset_n !== 1'b1 && wait_cnt < reset_timeout)
    begin
      @(posedge fpga_clk_50);
      wait_cnt++;
    end
    if (hps_fpga_reset_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      timeouts++;
    end
    for (row_idx = 0; row_idx < n_rows; row_idx++)
    begin
      @(posedge fpga_clk_50);
      key       <= rows[row_idx].key;
      reset_req <= rows[row_idx].req;
      sw        <= rows[row_idx].sw;
      led_pio   <= rows[row_idx].led_pio;
      repeat (int'(rows[row_idx].hold) - 1) @(posedge fpga_clk_50);
    end
    wait_cnt = 0;   // last key change and pulses drain out
    while ((buttons != key || reset_req_n != '1) && wait_cnt < settle_timeout)
    begin
      @(posedge fpga_clk_50);
      wait_cnt++;
    end
    if (buttons != key || reset_req_n != '1)
    begin
      $display("timeout: outputs did not settle after the last row");
      timeouts++;
    end
    $display("check errors %0d, timeouts %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
